// ==== Makefile ====
# Verilator flow for the FSB to AXI writer

VERILATOR ?= verilator
TB_TOP    ?= tb_fsb_axi_writer
RTL_TOP   ?= fsb_axi_writer
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/fsb_axi_params.svh ====
// FSB to AXI writer constants
`ifndef FSB_AXI_PARAMS_SVH
`define FSB_AXI_PARAMS_SVH

// ---------------------------------------------------------------------------
// data path widths
// ---------------------------------------------------------------------------
`define FSB_W        80
`define AXI_DATA_W   512
`define AXI_STRB_W   64
`define AXI_ADDR_W   64
`define AXI_ID_W     16

// bytes moved by one full beat
`define BEAT_BYTES   64

// configuration bus
`define CFG_DATA_W   32
`define CFG_ADDR_W   8

// ---------------------------------------------------------------------------
// register offsets
// ---------------------------------------------------------------------------
`define REG_CTRL     8'h08
`define REG_RESTART  8'h0C
`define REG_ADDR_LO  8'h20
`define REG_ADDR_HI  8'h24
`define REG_LEN      8'h2C
`define REG_SIZE     8'h30

`endif

// ==== logic/axi_wr_engine.sv ====
// AXI write burst engine
`timescale 1ns/1ps
`include "fsb_axi_params.svh"

module axi_wr_engine
   import axi_wr_pkg::*;
   import fsb_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       sync_rst_n,
   input  wr_setup_t  setup,
   input  wr_cmd_t    cmd,
   output wr_status_t status,
   output logic       engine_idle,
   input  logic       beat_valid,
   input  axi_data_t  beat_data,
   output logic       beat_take,
   output axi_aw_t    aw,
   output logic       awvalid,
   input  logic       awready,
   output axi_w_t     w,
   output logic       wvalid,
   input  logic       wready,
   input  axi_b_t     b,
   input  logic       bvalid,
   output logic       bready
);

   localparam logic [2:0] AW_SIZE = 3'($clog2(`BEAT_BYTES));

   wr_state_t state;
   wr_state_t state_nxt;
   axi_addr_t addr_q;
   axi_len_t  len_q;
   axi_len_t  beat_cnt;
   cfg_data_t bytes_left;
   cfg_data_t burst_bytes;
   logic      stop_pend;
   axi_resp_t bresp_q;
   axi_data_t w_data_q;
   logic      w_last_q;
   logic      in_prog;
   logic      aw_fire;
   logic      w_fire;
   logic      last_fire;
   logic      xfer_done;

   assign burst_bytes = (cfg_data_t'(len_q) + cfg_data_t'(1)) * cfg_data_t'(`BEAT_BYTES);

   assign aw_fire   = awvalid && awready;
   assign w_fire    = wvalid && wready;
   assign last_fire = w_fire && w_last_q;
   // this burst covers what is left
   assign xfer_done = (bytes_left <= burst_bytes);

   // ------------------------------------------------------------------------
   // state machine
   // ------------------------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE:
         begin
            if (cmd.go)
               state_nxt = ADDR;
         end
         ADDR:
         begin
            if (aw_fire)
               state_nxt = DATA;
         end
         DATA:
         begin
            if (last_fire)
               state_nxt = (xfer_done || stop_pend || cmd.stop) ? STOP : ADDR;
         end
         STOP:
         begin
            if (cmd.restart)
               state_nxt = IDLE;
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         state <= IDLE;
      else
         state <= state_nxt;
   end

   // soft stop waits for the burst in flight
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         stop_pend <= 1'b0;
      else
         stop_pend <= cmd.stop || (stop_pend && (state_nxt != IDLE));
   end

   // ------------------------------------------------------------------------
   // address and byte accounting
   // ------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (state == IDLE)
      begin
         addr_q     <= setup.base;
         len_q      <= setup.len;
         bytes_left <= setup.xfer_size;
      end
      else
      begin
         if (aw_fire)
            addr_q <= addr_q + axi_addr_t'(burst_bytes);
         if (last_fire)
            bytes_left <= bytes_left - burst_bytes;
      end
   end

   assign awvalid = (state == ADDR);
   assign aw = '{id: {`AXI_ID_W{1'b0}}, addr: addr_q, len: len_q, size: AW_SIZE};

   // ------------------------------------------------------------------------
   // write data
   // ------------------------------------------------------------------------

   // no new beat once the last one is loaded
   assign beat_take = (state == DATA) && beat_valid && !(wvalid && w_last_q)
                      && (!wvalid || wready);

   always_ff @(posedge clk)
   begin
      if (aw_fire)
         beat_cnt <= '0;
      else if (beat_take)
         beat_cnt <= beat_cnt + axi_len_t'(1);
   end

   always_ff @(posedge clk)
   begin
      if (beat_take)
      begin
         w_data_q <= beat_data;
         w_last_q <= (beat_cnt == len_q);
      end
   end

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         wvalid <= 1'b0;
      else if (beat_take)
         wvalid <= 1'b1;
      else if (w_fire)
         wvalid <= 1'b0;
   end

   assign w = '{data: w_data_q, strb: {`AXI_STRB_W{1'b1}}, last: w_last_q};

   // ------------------------------------------------------------------------
   // response and status
   // ------------------------------------------------------------------------
   assign bready = 1'b1;

   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
         bresp_q <= '0;
      else if (bvalid && bready && (b.id == {`AXI_ID_W{1'b0}}))
         bresp_q <= b.resp;
   end

   assign in_prog          = (state == ADDR) || (state == DATA);
   assign engine_idle      = !in_prog;
   assign status.in_prog   = in_prog;
   assign status.stop_pend = stop_pend;
   assign status.bresp     = bresp_q;

   aw_w_excl_a: assert property (@(posedge clk) disable iff (!sync_rst_n)
      !(awvalid && wvalid));

   aw_stable_a: assert property (@(posedge clk) disable iff (!sync_rst_n)
      awvalid && !awready |=> awvalid && $stable(aw));

endmodule

// ==== logic/axi_wr_pkg.sv ====
// AXI write channel types
`include "fsb_axi_params.svh"

package axi_wr_pkg;

   // byte address and one data beat
   typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [`AXI_DATA_W-1:0] axi_data_t;
   typedef logic [`AXI_STRB_W-1:0] axi_strb_t;

   // beats in a burst minus one
   typedef logic [7:0] axi_len_t;

   // OKAY, EXOKAY, SLVERR, DECERR
   typedef logic [1:0] axi_resp_t;

   // write address channel payload
   typedef struct packed {
      logic [`AXI_ID_W-1:0] id;
      axi_addr_t            addr;
      axi_len_t             len;
      logic [2:0]           size;
   } axi_aw_t;

   // write data channel payload
   typedef struct packed {
      axi_data_t data;
      axi_strb_t strb;
      logic      last;
   } axi_w_t;

   // write response channel payload
   typedef struct packed {
      logic [`AXI_ID_W-1:0] id;
      axi_resp_t            resp;
   } axi_b_t;

endpackage

// ==== logic/cfg_regs.sv ====
// configuration register file
`timescale 1ns/1ps
`include "fsb_axi_params.svh"

module cfg_regs
   import fsb_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       sync_rst_n,
   input  cfg_req_t   req,
   output cfg_rsp_t   rsp,
   input  wr_status_t status,
   output wr_setup_t  setup,
   output wr_cmd_t    cmd
);

   logic      pend_wr;
   logic      pend_rd;
   logic      ack;
   cfg_addr_t addr_q;
   cfg_data_t wdata_q;
   cfg_data_t rdata_q;
   cfg_data_t rd_mux;
   logic      wr_now;
   logic      wr_ack;
   cfg_data_t base_lo;
   cfg_data_t base_hi;
   cfg_data_t len_reg;
   cfg_data_t size_reg;

   // ------------------------------------------------------------------------
   // bus front end
   // ------------------------------------------------------------------------

   // strobe stretched until the ack goes out
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         pend_wr <= 1'b0;
         pend_rd <= 1'b0;
         ack     <= 1'b0;
      end
      else
      begin
         pend_wr <= req.wr || (pend_wr && !ack);
         pend_rd <= req.rd || (pend_rd && !ack);
         ack     <= (pend_wr || pend_rd) && !ack;
      end
   end

   always_ff @(posedge clk)
   begin
      if (req.wr || req.rd)
      begin
         addr_q  <= req.addr;
         wdata_q <= req.wdata;
      end
   end

   // register write happens once, one cycle after the strobe
   assign wr_now = pend_wr && !ack;
   assign wr_ack = pend_wr && ack;

   // ------------------------------------------------------------------------
   // setup registers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n)
      begin
         base_lo  <= '0;
         base_hi  <= '0;
         len_reg  <= '0;
         size_reg <= '0;
      end
      else if (wr_now)
      begin
         case (addr_q)
            `REG_ADDR_LO: base_lo  <= wdata_q;
            `REG_ADDR_HI: base_hi  <= wdata_q;
            `REG_LEN:     len_reg  <= wdata_q;
            `REG_SIZE:    size_reg <= wdata_q;
            default:      ;
         endcase
      end
   end

   assign setup.base      = {base_hi, base_lo};
   assign setup.len       = len_reg[7:0];
   assign setup.xfer_size = size_reg;

   // commands fire in the ack cycle
   assign cmd.go      = wr_ack && (addr_q == `REG_CTRL) && wdata_q[0];
   assign cmd.stop    = wr_ack && (addr_q == `REG_CTRL) && !wdata_q[0];
   assign cmd.restart = wr_ack && (addr_q == `REG_RESTART) && wdata_q[0];

   // ------------------------------------------------------------------------
   // readback
   // ------------------------------------------------------------------------
   always_comb
   begin
      case (addr_q)
         `REG_CTRL:    rd_mux = cfg_data_t'({status.bresp, status.stop_pend, status.in_prog});
         `REG_RESTART: rd_mux = '0;
         `REG_ADDR_LO: rd_mux = base_lo;
         `REG_ADDR_HI: rd_mux = base_hi;
         `REG_LEN:     rd_mux = len_reg;
         `REG_SIZE:    rd_mux = size_reg;
         default:      rd_mux = '1;
      endcase
   end

   // sampled the cycle before the ack
   always_ff @(posedge clk)
   begin
      if ((pend_wr || pend_rd) && !ack)
         rdata_q <= rd_mux;
   end

   assign rsp.ack   = ack;
   assign rsp.rdata = rdata_q;

   // ack follows each strobe by two cycles
   ack_delay_a: assert property (@(posedge clk) disable iff (!sync_rst_n)
      $past(req.wr || req.rd, 2) |-> ack);

endmodule

// ==== logic/fsb_axi_writer.sv ====
// FSB to AXI writer top level
`timescale 1ns/1ps

module fsb_axi_writer
   import axi_wr_pkg::*;
   import fsb_cfg_pkg::*;
(
   input  logic     clk,
   input  logic     sync_rst_n,
   input  cfg_req_t cfg_req,
   output cfg_rsp_t cfg_rsp,
   input  logic     fsb_wvalid,
   input  fsb_pkt_t fsb_wdata,
   output logic     fsb_yumi,
   output axi_aw_t  aw,
   output logic     awvalid,
   input  logic     awready,
   output axi_w_t   w,
   output logic     wvalid,
   input  logic     wready,
   input  axi_b_t   b,
   input  logic     bvalid,
   output logic     bready
);

   wr_setup_t  setup;
   wr_cmd_t    cmd;
   wr_status_t status;
   logic       engine_idle;
   logic       beat_valid;
   axi_data_t  beat_data;
   logic       beat_take;

   cfg_regs u_cfg_regs (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .req        (cfg_req),
      .rsp        (cfg_rsp),
      .status     (status),
      .setup      (setup),
      .cmd        (cmd)
   );

   fsb_beat_packer u_packer (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .engine_idle (engine_idle),
      .fsb_wvalid  (fsb_wvalid),
      .fsb_wdata   (fsb_wdata),
      .fsb_yumi    (fsb_yumi),
      .beat_valid  (beat_valid),
      .beat_data   (beat_data),
      .beat_take   (beat_take)
   );

   axi_wr_engine u_engine (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .setup       (setup),
      .cmd         (cmd),
      .status      (status),
      .engine_idle (engine_idle),
      .beat_valid  (beat_valid),
      .beat_data   (beat_data),
      .beat_take   (beat_take),
      .aw          (aw),
      .awvalid     (awvalid),
      .awready     (awready),
      .w           (w),
      .wvalid      (wvalid),
      .wready      (wready),
      .b           (b),
      .bvalid      (bvalid),
      .bready      (bready)
   );

endmodule

// ==== logic/fsb_beat_packer.sv ====
// FSB packet to beat packer
`timescale 1ns/1ps
`include "fsb_axi_params.svh"

module fsb_beat_packer
   import axi_wr_pkg::*;
   import fsb_cfg_pkg::*;
(
   input  logic      clk,
   input  logic      sync_rst_n,
   input  logic      engine_idle,
   input  logic      fsb_wvalid,
   input  fsb_pkt_t  fsb_wdata,
   output logic      fsb_yumi,
   output logic      beat_valid,
   output axi_data_t beat_data,
   input  logic      beat_take
);

   // one beat plus one packet of headroom
   localparam int ACC_W = `AXI_DATA_W + `FSB_W;
   localparam int CNT_W = $clog2(ACC_W + 1);

   logic [ACC_W-1:0] acc;
   logic [CNT_W-1:0] cnt;
   logic             move;
   logic [ACC_W-1:0] acc_keep;
   logic [CNT_W-1:0] cnt_keep;
   logic [ACC_W-1:0] pkt_ext;

   // ------------------------------------------------------------------------
   // accumulator
   // ------------------------------------------------------------------------

   // accept while a whole packet still fits
   assign fsb_yumi = fsb_wvalid && !engine_idle && (cnt <= CNT_W'(`AXI_DATA_W));

   // a full beat moves out once the beat register is free
   assign move = (cnt >= CNT_W'(`AXI_DATA_W)) && (!beat_valid || beat_take);

   always_comb
   begin
      acc_keep = acc;
      cnt_keep = cnt;
      if (move)
      begin
         acc_keep = acc >> `AXI_DATA_W;
         cnt_keep = cnt - CNT_W'(`AXI_DATA_W);
      end
   end

   assign pkt_ext = {{(ACC_W - `FSB_W){1'b0}}, fsb_wdata};

   // bits above cnt stay zero, so a new packet is simply or-ed in
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n || engine_idle)
      begin
         acc <= '0;
         cnt <= '0;
      end
      else if (fsb_yumi)
      begin
         acc <= acc_keep | (pkt_ext << cnt_keep);
         cnt <= cnt_keep + CNT_W'(`FSB_W);
      end
      else
      begin
         acc <= acc_keep;
         cnt <= cnt_keep;
      end
   end

   // ------------------------------------------------------------------------
   // finished beat
   // ------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!sync_rst_n || engine_idle)
         beat_valid <= 1'b0;
      else if (move)
         beat_valid <= 1'b1;
      else if (beat_take)
         beat_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (move)
         beat_data <= acc[`AXI_DATA_W-1:0];
   end

   take_needs_valid_a: assert property (@(posedge clk) disable iff (!sync_rst_n)
      beat_take |-> beat_valid);

endmodule

// ==== logic/fsb_cfg_pkg.sv ====
// configuration and packet side types
`include "fsb_axi_params.svh"

package fsb_cfg_pkg;

   typedef logic [`FSB_W-1:0]      fsb_pkt_t;
   typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;
   typedef logic [`CFG_DATA_W-1:0] cfg_data_t;

   // host strobes are single cycle
   typedef struct packed {
      logic      wr;
      logic      rd;
      cfg_addr_t addr;
      cfg_data_t wdata;
   } cfg_req_t;

   typedef struct packed {
      logic      ack;
      cfg_data_t rdata;
   } cfg_rsp_t;

   // programmed transfer, held as levels
   typedef struct packed {
      axi_wr_pkg::axi_addr_t base;
      axi_wr_pkg::axi_len_t  len;
      cfg_data_t             xfer_size;
   } wr_setup_t;

   // one-cycle command pulses
   typedef struct packed {
      logic go;
      logic stop;
      logic restart;
   } wr_cmd_t;

   typedef struct packed {
      logic                  in_prog;
      logic                  stop_pend;
      axi_wr_pkg::axi_resp_t bresp;
   } wr_status_t;

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      ADDR = 2'd1,
      DATA = 2'd2,
      STOP = 2'd3
   } wr_state_t;

endpackage

// ==== sim.f ====
+incdir+include
logic/axi_wr_pkg.sv
logic/fsb_cfg_pkg.sv
logic/cfg_regs.sv
logic/fsb_beat_packer.sv
logic/axi_wr_engine.sv
logic/fsb_axi_writer.sv
test/tb_fsb_axi_writer.sv

// ==== test/tb_fsb_axi_writer.sv ====
// FSB to AXI writer testbench
`timescale 1ns/1ps
`include "fsb_axi_params.svh"

module tb_fsb_axi_writer
   import axi_wr_pkg::*;
   import fsb_cfg_pkg::*;
();

   logic     clk;
   logic     sync_rst_n;
   cfg_req_t cfg_req;
   cfg_rsp_t cfg_rsp;
   logic     fsb_wvalid;
   fsb_pkt_t fsb_wdata;
   logic     fsb_yumi;
   axi_aw_t  aw;
   logic     awvalid;
   logic     awready;
   axi_w_t   w;
   logic     wvalid;
   logic     wready;
   axi_b_t   b;
   logic     bvalid;
   logic     bready;

   // reference model state
   fsb_pkt_t  pkts[$];
   axi_addr_t base_m;
   int        len_m;
   int        aw_count;
   int        beat_count;
   int        b_pend;
   axi_resp_t last_resp;
   int        errors;
   int        checks;
   logic      stream_on;
   logic [31:0] rd;

   fsb_axi_writer DUT (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg_req    (cfg_req),
      .cfg_rsp    (cfg_rsp),
      .fsb_wvalid (fsb_wvalid),
      .fsb_wdata  (fsb_wdata),
      .fsb_yumi   (fsb_yumi),
      .aw         (aw),
      .awvalid    (awvalid),
      .awready    (awready),
      .w          (w),
      .wvalid     (wvalid),
      .wready     (wready),
      .b          (b),
      .bvalid     (bvalid),
      .bready     (bready)
   );

   always #5 clk = ~clk;

   // slice of the continuous packet stream
   function automatic axi_data_t model_beat(input int k);
      axi_data_t r;
      int        g;
      r = '0;
      for (int i = 0; i < `AXI_DATA_W; i++)
      begin
         g = k * `AXI_DATA_W + i;
         if (g / `FSB_W < pkts.size())
            r[i] = pkts[g / `FSB_W][g % `FSB_W];
      end
      return r;
   endfunction

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("mismatch %s expected %h actual %h", name, exp, act);
      end
   endtask

   // ------------------------------------------------------------------------
   // random stimulus, driven on the falling edge
   // ------------------------------------------------------------------------
   always @(negedge clk)
   begin
      if (sync_rst_n)
      begin
         fsb_wvalid <= stream_on && ($urandom % 4 != 0);
         fsb_wdata  <= fsb_pkt_t'({$urandom, $urandom, $urandom});
         awready    <= ($urandom % 2 == 0);
         wready     <= ($urandom % 10 < 7);
         if (b_pend > 0 && ($urandom % 2 == 0))
         begin
            bvalid <= 1'b1;
            b.id   <= '0;
            b.resp <= 2'($urandom);
            b_pend--;
         end
         else
            bvalid <= 1'b0;
      end
   end

   // last response handed to the DUT
   always @(posedge clk)
   begin
      if (bvalid)
         last_resp = b.resp;
   end

   // ------------------------------------------------------------------------
   // monitor and checks against the model
   // ------------------------------------------------------------------------
   always @(posedge clk)
   begin
      if (sync_rst_n)
      begin
         if (fsb_wvalid && fsb_yumi)
            pkts.push_back(fsb_wdata);
         if (awvalid && awready)
         begin
            check_val("aw addr", base_m + axi_addr_t'(64 * aw_count * (len_m + 1)), aw.addr);
            check_val("aw len", 64'(len_m), 64'(aw.len));
            check_val("aw size", 64'd6, 64'(aw.size));
            check_val("aw id", 64'd0, 64'(aw.id));
            aw_count++;
         end
         if (wvalid && wready)
         begin
            checks++;
            if (w.data !== model_beat(beat_count))
            begin
               errors++;
               $display("mismatch beat %0d expected %h actual %h", beat_count,
                        model_beat(beat_count), w.data);
            end
            check_val("wstrb", '1, w.strb);
            check_val("wlast", 64'((beat_count % (len_m + 1)) == len_m), 64'(w.last));
            if (w.last)
               b_pend++;
            beat_count++;
         end
         if (bvalid)
            check_val("bready", 64'd1, 64'(bready));
      end
   end

   // one bus access, returns read data, checks the ack delay
   task automatic cfg_access(input logic is_wr, input cfg_addr_t a, input cfg_data_t d,
                             output cfg_data_t rdata);
      int n;
      cfg_req.wr    = is_wr;
      cfg_req.rd    = !is_wr;
      cfg_req.addr  = a;
      cfg_req.wdata = d;
      @(negedge clk);
      cfg_req.wr = 1'b0;
      cfg_req.rd = 1'b0;
      n = 1;
      while (!cfg_rsp.ack && n < 20)
      begin
         @(negedge clk);
         n++;
      end
      if (!cfg_rsp.ack)
      begin
         errors++;
         $display("timeout waiting for configuration ack");
      end
      check_val("ack delay", 64'd2, 64'(n));
      rdata = cfg_rsp.rdata;
   endtask

   task automatic setup_xfer(input int len, input int nb);
      cfg_data_t dummy;
      base_m = {$urandom, $urandom};
      len_m  = len;
      cfg_access(1'b1, `REG_ADDR_LO, base_m[31:0], dummy);
      cfg_access(1'b1, `REG_ADDR_HI, base_m[63:32], dummy);
      cfg_access(1'b1, `REG_LEN, cfg_data_t'(len), dummy);
      cfg_access(1'b1, `REG_SIZE, cfg_data_t'(nb * (len + 1) * 64), dummy);
      pkts.delete();
      aw_count   = 0;
      beat_count = 0;
      cfg_access(1'b1, `REG_CTRL, 32'd1, dummy);
   endtask

   // poll until in-progress clears and all responses are sent
   task automatic wait_done(input string name);
      cfg_data_t r;
      int        n;
      n = 0;
      r = 32'd1;
      while (r[0] && n < 2000)
      begin
         cfg_access(1'b0, `REG_CTRL, '0, r);
         n++;
      end
      if (r[0])
      begin
         errors++;
         $display("timeout in %s, transfer never ended", name);
      end
      n = 0;
      while (b_pend > 0 && n < 200)
      begin
         @(negedge clk);
         n++;
      end
      if (b_pend > 0)
      begin
         errors++;
         $display("timeout in %s, write responses still pending", name);
      end
      repeat (2) @(negedge clk);
      cfg_access(1'b0, `REG_CTRL, '0, r);
      check_val({name, " bresp"}, 64'(last_resp), 64'(r[3:2]));
   endtask

   task automatic run_transfer(input string name);
      int len;
      int nb;
      len = $urandom % 4;
      nb  = 2 + $urandom % 3;
      setup_xfer(len, nb);
      wait_done(name);
      check_val({name, " bursts"}, 64'(nb), 64'(aw_count));
      check_val({name, " beats"}, 64'(nb * (len + 1)), 64'(beat_count));
   endtask

   task automatic soft_stop();
      cfg_data_t dummy;
      int        n;
      int        aw0;
      int        extra;
      setup_xfer(3, 10);
      n = 0;
      while (aw_count < 2 && n < 1000)
      begin
         @(negedge clk);
         n++;
      end
      if (aw_count < 2)
      begin
         errors++;
         $display("timeout in soft stop, bursts never started");
      end
      cfg_access(1'b1, `REG_CTRL, 32'd0, dummy);
      aw0   = aw_count;
      extra = awvalid ? 1 : 0;
      wait_done("soft stop");
      checks++;
      if (aw_count > aw0 + extra)
      begin
         errors++;
         $display("soft stop failed, %0d address phases after the stop", aw_count - aw0);
      end
      check_val("soft stop beats", 64'(aw_count * 4), 64'(beat_count));
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      cfg_data_t v;
      cfg_addr_t regs[4];
      void'($urandom(89));
      clk        = 1'b0;
      sync_rst_n = 1'b0;
      cfg_req    = '0;
      fsb_wvalid = 1'b0;
      fsb_wdata  = '0;
      awready    = 1'b0;
      wready     = 1'b0;
      b          = '0;
      bvalid     = 1'b0;
      stream_on  = 1'b0;
      errors     = 0;
      checks     = 0;
      b_pend     = 0;
      aw_count   = 0;
      beat_count = 0;
      len_m      = 0;
      base_m     = '0;
      last_resp  = '0;
      regs = '{`REG_ADDR_LO, `REG_ADDR_HI, `REG_LEN, `REG_SIZE};
      repeat (4) @(negedge clk);
      sync_rst_n = 1'b1;
      @(negedge clk);

      // outputs right after reset
      check_val("reset awvalid", 64'd0, 64'(awvalid));
      check_val("reset wvalid", 64'd0, 64'(wvalid));
      check_val("reset fsb_yumi", 64'd0, 64'(fsb_yumi));
      check_val("reset ack", 64'd0, 64'(cfg_rsp.ack));
      check_val("reset bready", 64'd1, 64'(bready));

      // register readback
      foreach (regs[i])
      begin
         v = $urandom;
         cfg_access(1'b1, regs[i], v, rd);
         cfg_access(1'b0, regs[i], '0, rd);
         check_val("readback", 64'(v), 64'(rd));
      end
      cfg_access(1'b0, 8'h40, '0, rd);
      check_val("unknown offset", 64'hffff_ffff, 64'(rd));

      stream_on = 1'b1;
      run_transfer("transfer");
      cfg_access(1'b1, `REG_RESTART, 32'd1, rd);
      soft_stop();
      cfg_access(1'b1, `REG_RESTART, 32'd1, rd);
      run_transfer("restart");
      stream_on = 1'b0;
      repeat (4) @(negedge clk);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule
